// ==== verification/leading_digit_vectors.txt ====
// value_in  digit  decade  invalid   (hex fields, one test per line)
// Repeated single-precision divide by ten, nearest even, while the value is at least ten.
3F800000 1 00 0
40200000 2 00 0
40490FDB 3 00 0
40A00000 5 00 0
40F80000 7 00 0
41000000 8 00 0
41100000 9 00 0
411FD70A 9 00 0
411FFFFF 9 00 0
3F000000 0 00 0
3727C5AC 0 00 0
00800000 0 00 0
41200000 1 01 0
42280000 4 01 0
42C60000 9 01 0
42C80000 1 02 0
447A0000 1 03 0
45FA0000 8 03 0
4640E400 1 04 0
48F42400 5 05 0
4E6E6B28 1 09 0
501502F9 1 0A 0
5F800000 1 13 0
6222A15D 7 14 0
67800000 1 18 0
71800000 1 1E 0
7F000000 1 26 0
7F7FFFFF 3 26 0
00000000 0 00 1
80000000 0 00 1
00000001 0 00 1
007FFFFF 0 00 1
BF800000 0 00 1
C1200000 0 00 1
7F800000 0 00 1
7FC00000 0 00 1

// ==== files.f ====
src/decade_pkg.sv
src/div_if.sv
src/div_by_ten.sv
src/decade_ctrl.sv
src/leading_digit_top.sv
verification/leading_digit_checker.sv
verification/tb_leading_digit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_leading_digit
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_leading_digit.sv ====
`timescale 1ns/10ps

module tb_leading_digit;
	import decade_pkg::*;

	localparam int MAX_TESTS   = 64;
	localparam int CLK_PERIOD  = 8;
	localparam int TEST_CYCLES = 3 + 30 * MAX_DECADES_DEFAULT + 10;

	logic    clk;
	logic    rst_n;
	logic    start;
	float_t  value_in;
	logic    busy;
	logic    done;
	digit_t  digit;
	decade_t decade;
	logic    invalid;
	digit_t  exp_digit;
	decade_t exp_decade;
	logic    exp_invalid;
	int      tests_done;
	int      fail_count;

	logic [31:0] vec_mem [0:4*MAX_TESTS-1];   // Four words per test.
	int          num_tests;
	logic        loaded;
	int          seed;

	leading_digit_top #(
		.MAX_DECADES (MAX_DECADES_DEFAULT)
	) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.value_in (value_in),
		.busy     (busy),
		.done     (done),
		.digit    (digit),
		.decade   (decade),
		.invalid  (invalid)
	);

	leading_digit_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.value_in    (value_in),
		.busy        (busy),
		.done        (done),
		.digit       (digit),
		.decade      (decade),
		.invalid     (invalid),
		.exp_digit   (exp_digit),
		.exp_decade  (exp_decade),
		.exp_invalid (exp_invalid),
		.tests_done  (tests_done),
		.fail_count  (fail_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic load_vectors();
		for (int i = 0; i < 4 * MAX_TESTS; i++)
			vec_mem[i] = 32'hf000_0000 | i;   // Invalid column never reads above one.
		$readmemh("verification/leading_digit_vectors.txt", vec_mem);
		num_tests = 0;
		while ((num_tests < MAX_TESTS) && (vec_mem[4*num_tests+3] <= 1))
			num_tests++;
		loaded = 1'b1;
	endtask

	// Starts one test, throws in a stray start while busy, waits for done.
	task automatic run_test(input int idx);
		int   stray_at;
		int   cyc;
		logic finished;
		value_in    = vec_mem[4*idx];
		exp_digit   = digit_t'(vec_mem[4*idx+1]);
		exp_decade  = decade_t'(vec_mem[4*idx+2]);
		exp_invalid = vec_mem[4*idx+3][0];
		start       = 1'b1;
		@(posedge clk);
		#1;
		start    = 1'b0;
		value_in = $random(seed);
		stray_at = {$random(seed)} % 48;
		cyc      = 0;
		finished = 1'b0;
		while (!finished)
		begin
			if ((cyc == stray_at) && busy)
			begin
				start    = 1'b1;
				value_in = $random(seed);
			end
			@(posedge clk);
			#1;
			start    = 1'b0;
			cyc++;
			finished = done;
		end
		// Two idle cycles with the result held on the outputs.
		repeat (2) @(posedge clk);
		#1;
	endtask

	initial
	begin
		int limit;
		wait (loaded);
		limit = num_tests * TEST_CYCLES + 32;
		repeat (limit) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clock cycles.", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		seed        = 32'h8ea9;
		clk         = 1'b0;
		rst_n       = 1'b0;
		start       = 1'b0;
		value_in    = '0;
		exp_digit   = '0;
		exp_decade  = '0;
		exp_invalid = 1'b0;
		loaded      = 1'b0;
		load_vectors();
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (5) @(posedge clk);   // Quiet stretch before the first start.
		#1;
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		repeat (3) @(posedge clk);
		if (tests_done != num_tests)
			$display("Error: only %0d of %0d tests finished.", tests_done, num_tests);
		$display("Tests: %0d run, %0d passed, %0d failed", tests_done,
			tests_done - fail_count, fail_count);
		if ((fail_count == 0) && (tests_done == num_tests))
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== verification/leading_digit_checker.sv ====
`timescale 1ns/10ps

module leading_digit_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  decade_pkg::float_t  value_in,
	input  logic                busy,
	input  logic                done,
	input  decade_pkg::digit_t  digit,
	input  decade_pkg::decade_t decade,
	input  logic                invalid,
	input  decade_pkg::digit_t  exp_digit,
	input  decade_pkg::decade_t exp_decade,
	input  logic                exp_invalid,
	output int                  tests_done,
	output int                  fail_count
);
	import decade_pkg::*;

	logic    pending;
	logic    holding;
	logic    seen_start;
	logic    early_flagged;
	float_t  value_r;
	digit_t  exp_digit_r;
	decade_t exp_decade_r;
	logic    exp_invalid_r;
	digit_t  held_digit;
	decade_t held_decade;
	logic    held_invalid;

	// Sampling on the falling edge keeps clear of DUT updates.
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			tests_done    = 0;
			fail_count    = 0;
			pending       = 1'b0;
			holding       = 1'b0;
			seen_start    = 1'b0;
			early_flagged = 1'b0;
		end
		else
		begin
			if (!seen_start && (busy || done) && !early_flagged)
			begin
				$display("Error at %0t ns: busy or done rose before the first start.", $time);
				fail_count++;
				early_flagged = 1'b1;
			end
			if (holding && ({digit, decade, invalid} !=
				{held_digit, held_decade, held_invalid}))
			begin
				$display("[FAIL] %0t ns: result of test %0d changed before the next start",
					$time, tests_done);
				fail_count++;
				holding = 1'b0;
			end
			if (done)
			begin
				if (!pending)
				begin
					$display("Error at %0t ns: done pulsed with no test running.", $time);
					fail_count++;
				end
				else
				begin
					tests_done++;
					if ((digit != exp_digit_r) || (decade != exp_decade_r) ||
						(invalid != exp_invalid_r))
					begin
						$display("[FAIL] %0t ns: test %0d %08h got %0d %0d %0b, want %0d %0d %0b",
							$time, tests_done, value_r, digit, decade, invalid,
							exp_digit_r, exp_decade_r, exp_invalid_r);
						fail_count++;
					end
					else
						$display("[PASS] test %0d value %08h digit %0d decade %0d invalid %0b",
							tests_done, value_r, digit, decade, invalid);
					pending      = 1'b0;
					holding      = 1'b1;   // Outputs must now stay put.
					held_digit   = digit;
					held_decade  = decade;
					held_invalid = invalid;
				end
			end
			// Only a start seen while idle counts as a new test.
			if (start && !busy)
			begin
				seen_start    = 1'b1;
				pending       = 1'b1;
				holding       = 1'b0;
				value_r       = value_in;
				exp_digit_r   = exp_digit;
				exp_decade_r  = exp_decade;
				exp_invalid_r = exp_invalid;
			end
		end
	end

endmodule

// ==== src/leading_digit_top.sv ====
`timescale 1ns/10ps

module leading_digit_top #(
	parameter int MAX_DECADES = decade_pkg::MAX_DECADES_DEFAULT
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  decade_pkg::float_t  value_in,
	output logic                busy,
	output logic                done,
	output decade_pkg::digit_t  digit,
	output decade_pkg::decade_t decade,
	output logic                invalid
);

	// Request and result path to the divider.
	div_if div_bus ();

	decade_ctrl #(
		.MAX_DECADES (MAX_DECADES)
	) u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.value_in (value_in),
		.bus      (div_bus.ctrl),
		.busy     (busy),
		.done     (done),
		.digit    (digit),
		.decade   (decade),
		.invalid  (invalid)
	);

	div_by_ten u_div (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (div_bus.unit)
	);

endmodule

// ==== src/decade_ctrl.sv ====
`timescale 1ns/10ps

module decade_ctrl #(
	parameter int MAX_DECADES = decade_pkg::MAX_DECADES_DEFAULT
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  decade_pkg::float_t  value_in,
	div_if.ctrl                 bus,
	output logic                busy,
	output logic                done,
	output decade_pkg::digit_t  digit,
	output decade_pkg::decade_t decade,
	output logic                invalid
);
	import decade_pkg::*;

	ctrl_state_t       state;
	float_t            value_r;
	decade_t           decade_cnt;
	logic              bad_r;

	logic              val_sign;
	exp_t              val_exp;
	logic [FRAC_W-1:0] val_frac;
	logic              not_normal;
	logic              ten_or_more;
	logic              at_limit;
	logic [7:0]        shift_amt;
	mant_t             int_part;

	assign val_sign = value_r[FRAC_W + $bits(exp_t)];
	assign val_exp  = value_r[FRAC_W +: $bits(exp_t)];
	assign val_frac = value_r[FRAC_W-1:0];

	// Zero, subnormal, infinity, NaN or negative.
	assign not_normal = val_sign || (val_exp == '0) || (val_exp == '1);

	assign ten_or_more = (val_exp > TEN_EXP) ||
		((val_exp == TEN_EXP) && (val_frac >= TEN_FRAC));

	assign at_limit = (decade_cnt == decade_t'(MAX_DECADES));

	// Integer part of the value.
	// Below one the shift reaches 24 or more and the part is zero.
	assign shift_amt = 8'(FRAC_W + EXP_BIAS) - val_exp;
	assign int_part  = {1'b1, val_frac} >> shift_amt;

	assign bus.operand = value_r;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= IDLE;
			busy       <= 1'b0;
			done       <= 1'b0;
			bus.go     <= 1'b0;
			decade_cnt <= '0;
			bad_r      <= 1'b0;
			digit      <= '0;
			decade     <= '0;
			invalid    <= 1'b0;
		end
		else
		begin
			done   <= 1'b0;
			bus.go <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state      <= CHECK;
						busy       <= 1'b1;
						decade_cnt <= '0;
						bad_r      <= 1'b0;
					end
				end
				CHECK:
				begin
					if (not_normal || (ten_or_more && at_limit))
					begin
						bad_r <= 1'b1;
						state <= FINISH;
					end
					else if (ten_or_more)
					begin
						bus.go <= 1'b1;   // Divider is idle here.
						state  <= DIVIDE;
					end
					else
					begin
						state <= FINISH;
					end
				end
				DIVIDE:
				begin
					if (bus.ready)
					begin
						decade_cnt <= decade_cnt + 1'b1;
						state      <= CHECK;
					end
				end
				FINISH:
				begin
					state   <= IDLE;
					busy    <= 1'b0;
					done    <= 1'b1;
					invalid <= bad_r;
					digit   <= bad_r ? '0 : digit_t'(int_part);
					decade  <= bad_r ? '0 : decade_cnt;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Working value, replaced by each quotient.
	always_ff @(posedge clk)
	begin
		if ((state == IDLE) && start)
			value_r <= value_in;
		else if ((state == DIVIDE) && bus.ready)
			value_r <= bus.quotient;
	end

	a_digit_decimal: assert property (@(posedge clk) disable iff (!rst_n)
		(done && !invalid) |-> (digit < 4'd10))
		else $error("Leading digit is not a decimal digit.");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("Done held for more than one cycle.");

endmodule

// ==== src/div_by_ten.sv ====
`timescale 1ns/10ps

module div_by_ten (
	input  logic clk,
	input  logic rst_n,
	div_if.unit  bus
);
	import decade_pkg::*;

	localparam mant_t TEN_MANT = {1'b1, TEN_FRAC};
	localparam int    CNT_W    = $clog2(QUOT_BITS + 1);
	localparam int    REM_W    = FRAC_W + 2;

	// Guard bit position when the integer quotient bit is set.
	localparam int    GUARD_HI = QUOT_BITS - FRAC_W - 2;

	logic                 running;
	logic [CNT_W-1:0]     step_cnt;
	logic                 last_step;
	logic [REM_W-1:0]     rem;
	logic [QUOT_BITS-1:0] quo;
	exp_t                 exp_in;
	logic                 sign_in;

	logic [REM_W-1:0]     rem_diff;
	logic                 rem_ge;
	mant_t                norm_mant;
	logic                 guard_bit;
	logic                 sticky_bit;
	logic                 round_up;
	logic [FRAC_W+1:0]    rounded;
	logic [FRAC_W-1:0]    frac_out;
	exp_t                 exp_out;

	assign last_step = (step_cnt == CNT_W'(QUOT_BITS));

	// Trial subtraction of the divisor mantissa.
	assign rem_ge   = (rem >= {1'b0, TEN_MANT});
	assign rem_diff = rem - {1'b0, TEN_MANT};

	// The mantissa ratio lies in [0.8, 1.6), so at most one normalizing shift.
	always_comb
	begin
		if (quo[QUOT_BITS-1])
		begin
			norm_mant  = quo[QUOT_BITS-1 -: FRAC_W+1];
			guard_bit  = quo[GUARD_HI];
			sticky_bit = (|quo[GUARD_HI-1:0]) | (|rem);
		end
		else
		begin
			norm_mant  = quo[QUOT_BITS-2 -: FRAC_W+1];
			guard_bit  = quo[GUARD_HI-1];
			sticky_bit = (|quo[GUARD_HI-2:0]) | (|rem);
		end
	end

	// Round to nearest, ties to even.
	assign round_up = guard_bit & (sticky_bit | norm_mant[0]);
	assign rounded  = {1'b0, norm_mant} + (FRAC_W+2)'(round_up);

	// A carry out of rounding leaves a zero fraction and bumps the exponent.
	assign frac_out = rounded[FRAC_W-1:0];

	// Divisor exponent is three; one more when the ratio is below one.
	assign exp_out = exp_in - exp_t'(quo[QUOT_BITS-1] ? 3 : 4)
		+ exp_t'(rounded[FRAC_W+1]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running   <= 1'b0;
			step_cnt  <= '0;
			bus.ready <= 1'b0;
		end
		else
		begin
			bus.ready <= 1'b0;
			if (bus.go && !running)
			begin
				running  <= 1'b1;
				step_cnt <= '0;
			end
			else if (running)
			begin
				if (last_step)
				begin
					running   <= 1'b0;
					bus.ready <= 1'b1;
				end
				else
				begin
					step_cnt <= step_cnt + 1'b1;
				end
			end
		end
	end

	// Restoring division, one quotient bit per cycle.
	always_ff @(posedge clk)
	begin
		if (bus.go && !running)
		begin
			rem     <= {1'b0, 1'b1, bus.operand[FRAC_W-1:0]};
			quo     <= '0;
			exp_in  <= bus.operand[FRAC_W +: $bits(exp_t)];
			sign_in <= bus.operand[FRAC_W + $bits(exp_t)];
		end
		else if (running && !last_step)
		begin
			if (rem_ge)
			begin
				rem <= {rem_diff[REM_W-2:0], 1'b0};
				quo <= {quo[QUOT_BITS-2:0], 1'b1};
			end
			else
			begin
				rem <= {rem[REM_W-2:0], 1'b0};
				quo <= {quo[QUOT_BITS-2:0], 1'b0};
			end
		end

		if (running && last_step)
			bus.quotient <= {sign_in, exp_out, frac_out};
	end

	a_go_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		bus.go |-> !running)
		else $error("Divide request arrived during a division.");

	// Operands are at least ten, so quotients are at least one.
	a_quot_at_least_one: assert property (@(posedge clk) disable iff (!rst_n)
		bus.ready |-> (bus.quotient[FRAC_W +: $bits(exp_t)] >= EXP_BIAS))
		else $error("Quotient exponent fell below the bias.");

endmodule

// ==== src/div_if.sv ====
`timescale 1ns/10ps

interface div_if;
	import decade_pkg::*;

	logic   go;         // One-cycle request.
	float_t operand;    // Stable until ready.
	logic   ready;      // One-cycle result strobe.
	float_t quotient;   // Held after ready.

	// Request side.
	modport ctrl (
		output go,
		output operand,
		input  ready,
		input  quotient
	);

	// Divider side.
	modport unit (
		input  go,
		input  operand,
		output ready,
		output quotient
	);

endinterface

// ==== src/decade_pkg.sv ====
package decade_pkg;

	// Single-precision field layout.
	localparam int FRAC_W   = 23;
	localparam int EXP_BIAS = 127;

	typedef logic [31:0]     float_t;
	typedef logic [7:0]      exp_t;
	typedef logic [FRAC_W:0] mant_t;   // Fraction with the hidden one.

	typedef logic [5:0] decade_t;
	typedef logic [3:0] digit_t;

	// Ten is 1.25 * 2^3, i.e. 32'h41200000.
	localparam exp_t              TEN_EXP  = 8'd130;
	localparam logic [FRAC_W-1:0] TEN_FRAC = 23'h200000;

	// Quotient bits before rounding.
	// One integer bit, 24 fraction bits, guard and round.
	localparam int QUOT_BITS = 27;

	// Forty divider stages in the flat version, decades 0 to 39.
	localparam int MAX_DECADES_DEFAULT = 39;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		CHECK  = 2'd1,
		DIVIDE = 2'd2,
		FINISH = 2'd3
	} ctrl_state_t;

endpackage
